/* common/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [15:0] wordT;  // Data word.
	typedef logic [15:0] addrT;  // Word address.
	typedef logic [1:0] regIdxT; // Selects R0 to R3.

	typedef enum logic [5:0] {
		opBra   = 6'd0,
		opBne   = 6'd1,
		opBeq   = 6'd2,
		opLsl   = 6'd7,
		opLsr   = 6'd8,
		opAnd   = 6'd12,
		opOrr   = 6'd13,
		opNot   = 6'd14,
		opXor   = 6'd15,
		opMovh  = 6'd17,
		opLd    = 6'd18,
		opSt    = 6'd19,
		opMovl  = 6'd20,
		opAdd   = 6'd21,
		opSub   = 6'd23,
		opMovar = 6'd32
	} opcodeT;

	// Register format, used by the ALU instructions.
	typedef struct packed {
		opcodeT     opcode;
		logic       setFlags; // Write z, c and n.
		regIdxT     dst;
		regIdxT     src1;
		regIdxT     src2;
		logic [2:0] unused;
	} regFormatT;

	// Immediate format, used by moves, memory access and branches.
	typedef struct packed {
		opcodeT     opcode;
		regIdxT     rx;
		logic [7:0] imm;      // Byte value or signed branch offset.
	} immFormatT;

	typedef union packed {
		regFormatT rType;
		immFormatT iType;
	} instrT;

	typedef enum logic [3:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNot,
		aluLsl,
		aluLsr
	} aluOpT;

	typedef enum logic [1:0] {
		wrSrcAlu,
		wrSrcImm,
		wrSrcBus
	} writeSrcT;

	typedef enum logic [1:0] {
		wrModeFull,
		wrModeLow,
		wrModeHigh
	} writeModeT;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flagsT;

endpackage

`default_nettype wire

/* common/ctrlIf.sv */
`default_nettype none

interface ctrlIf import cpuPkg::*; ();

	regIdxT     raSel;     // Read port A.
	regIdxT     rbSel;     // Read port B.
	logic       wrEn;
	regIdxT     wrSel;
	writeSrcT   wrSrc;
	writeModeT  wrMode;
	logic [7:0] immByte;   // Low byte of the instruction.
	aluOpT      aluOp;
	logic       flagWrite;
	logic       pcInc;
	logic       pcBranch;
	logic       arLoad;
	logic       useAr;     // AR drives the bus address.
	flagsT      flags;

	modport control (
		output raSel, rbSel, wrEn, wrSel, wrSrc, wrMode, immByte,
		output aluOp, flagWrite, pcInc, pcBranch, arLoad, useAr,
		input  flags
	);

	modport regs (input raSel, rbSel, wrEn, wrSel, wrSrc, wrMode, immByte);

	modport addr (input pcInc, pcBranch, arLoad, useAr, immByte);

	modport alu (input aluOp, flagWrite, output flags);

endinterface

`default_nettype wire

/* controlUnit/controlUnit.sv */
`default_nettype none

module controlUnit import cpuPkg::*; (
	input  wire logic  Clock,
	input  wire logic  rstN,
	ctrlIf.control     ctrl,
	output logic       wbCyc,
	output logic       wbStb,
	output logic       wbWe,
	input  wire logic  wbAck,
	input  wire wordT  wbDatR
);

	typedef enum logic [1:0] {
		stFetch,
		stExec,
		stMem
	} stateT;

	stateT  state;
	instrT  ir;
	logic   busCycle;    // Drives cyc and stb together.
	logic   writeCycle;
	logic   fetchDone;
	opcodeT op;
	aluOpT  aluSel;
	logic   isAluOp;
	logic   isMemOp;
	logic   branchTaken;

	// ##########################################################
	// Bus master and timing state
	// ##########################################################

	assign wbCyc = busCycle;
	assign wbStb = busCycle;
	assign wbWe = writeCycle;
	assign fetchDone = (state == stFetch) && busCycle && wbAck;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= stFetch;
			busCycle <= 1'b0;
			writeCycle <= 1'b0;
		end else begin
			case (state)
				stFetch: begin
					// Idle here only after reset or after a data access.
					if (!busCycle) begin
						busCycle <= 1'b1;
					end else if (wbAck) begin
						busCycle <= 1'b0;
						state <= stExec;
					end
				end
				stExec: begin
					busCycle <= 1'b1;            // Next fetch or the data access.
					writeCycle <= (op == opSt);
					state <= isMemOp ? stMem : stFetch;
				end
				stMem: begin
					if (wbAck) begin
						busCycle <= 1'b0;
						writeCycle <= 1'b0;
						state <= stFetch;
					end
				end
				default: state <= stFetch;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (fetchDone) begin
			ir <= wbDatR;
		end
	end

	// ##########################################################
	// Decode
	// ##########################################################

	assign op = ir.rType.opcode;
	assign isMemOp = (op == opLd) || (op == opSt);

	always_comb begin
		isAluOp = 1'b1;
		aluSel = aluPass;
		branchTaken = 1'b0;
		case (op)
			opAdd: aluSel = aluAdd;
			opSub: aluSel = aluSub;
			opAnd: aluSel = aluAnd;
			opOrr: aluSel = aluOr;
			opXor: aluSel = aluXor;
			opNot: aluSel = aluNot;
			opLsl: aluSel = aluLsl;
			opLsr: aluSel = aluLsr;
			default: isAluOp = 1'b0;
		endcase
		case (op)
			opBra: branchTaken = 1'b1;
			opBeq: branchTaken = ctrl.flags.z;
			opBne: branchTaken = !ctrl.flags.z;
			default: branchTaken = 1'b0;
		endcase
	end

	// ##########################################################
	// Datapath controls
	// ##########################################################

	assign ctrl.raSel = isAluOp ? ir.rType.src1 : ir.iType.rx; // Rx for ST and MOVAR.
	assign ctrl.rbSel = ir.rType.src2;
	assign ctrl.immByte = ir.iType.imm;
	assign ctrl.aluOp = aluSel;
	assign ctrl.pcInc = fetchDone;
	assign ctrl.useAr = (state == stMem);

	always_comb begin
		ctrl.wrEn = 1'b0;
		ctrl.wrSel = ir.iType.rx;
		ctrl.wrSrc = wrSrcAlu;
		ctrl.wrMode = wrModeFull;
		ctrl.flagWrite = 1'b0;
		ctrl.pcBranch = 1'b0;
		ctrl.arLoad = 1'b0;
		if (state == stExec) begin
			if (isAluOp) begin
				ctrl.wrEn = 1'b1;
				ctrl.wrSel = ir.rType.dst;
				ctrl.flagWrite = ir.rType.setFlags;
			end
			case (op)
				opMovl: begin
					ctrl.wrEn = 1'b1;
					ctrl.wrSrc = wrSrcImm;
					ctrl.wrMode = wrModeLow;
				end
				opMovh: begin
					ctrl.wrEn = 1'b1;
					ctrl.wrSrc = wrSrcImm;
					ctrl.wrMode = wrModeHigh;
				end
				opMovar: ctrl.arLoad = 1'b1;
				default: ctrl.arLoad = 1'b0;
			endcase
			ctrl.pcBranch = branchTaken;  // Offset is relative to the next PC.
		end else if (state == stMem && op == opLd) begin
			ctrl.wrEn = busCycle && wbAck; // Load data lands on the ack edge.
			ctrl.wrSrc = wrSrcBus;
		end
	end

endmodule

`default_nettype wire

/* datapath/registerFile.sv */
`default_nettype none

module registerFile import cpuPkg::*; (
	input  wire logic Clock,
	input  wire logic rstN,
	ctrlIf.regs       ctrl,
	input  wire wordT aluResult,
	input  wire wordT busData,
	output wordT      rdA,
	output wordT      rdB
);

	wordT regs [4];
	wordT wrData;

	always_comb begin
		case (ctrl.wrSrc)
			wrSrcImm: wrData = {8'h00, ctrl.immByte};
			wrSrcBus: wrData = busData;
			default:  wrData = aluResult;
		endcase
	end

	assign rdA = regs[ctrl.raSel];
	assign rdB = regs[ctrl.rbSel];

	// Byte modes take the low byte of the write data.
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.wrEn) begin
			case (ctrl.wrMode)
				wrModeLow:  regs[ctrl.wrSel][7:0] <= wrData[7:0];
				wrModeHigh: regs[ctrl.wrSel][15:8] <= wrData[7:0]; // MOVH.
				default:    regs[ctrl.wrSel] <= wrData;
			endcase
		end
	end

endmodule

`default_nettype wire

/* datapath/addressRegisters.sv */
`default_nettype none

module addressRegisters import cpuPkg::*; #(
	parameter addrT resetPc = 16'h0000
) (
	input  wire logic Clock,
	input  wire logic rstN,
	ctrlIf.addr       ctrl,
	input  wire wordT rdA,
	output addrT      busAddr
);

	addrT pc;
	addrT ar;
	addrT branchOffset;

	assign branchOffset = {{8{ctrl.immByte[7]}}, ctrl.immByte}; // Sign extended.

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (ctrl.pcInc) begin
			pc <= pc + 16'd1;
		end else if (ctrl.pcBranch) begin
			pc <= pc + branchOffset;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			ar <= '0;
		end else if (ctrl.arLoad) begin
			ar <= rdA;             // MOVAR.
		end
	end

	assign busAddr = ctrl.useAr ? ar : pc;

endmodule

`default_nettype wire

/* datapath/alu.sv */
`default_nettype none

module alu import cpuPkg::*; (
	input  wire logic Clock,
	input  wire logic rstN,
	ctrlIf.alu        ctrl,
	input  wire wordT a,
	input  wire wordT b,
	output wordT      result
);

	flagsT       flagsQ;
	logic        isSub;
	wordT        addend;
	logic [16:0] sum;
	logic        carry;

	// One adder serves ADD and SUB, subtraction as a + ~b + 1.
	assign isSub = (ctrl.aluOp == aluSub);
	assign addend = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, addend} + {16'd0, isSub};

	always_comb begin
		result = a;
		carry = flagsQ.c;          // Logic ops leave c alone.
		case (ctrl.aluOp)
			aluAdd, aluSub: begin
				result = sum[15:0];
				carry = sum[16];
			end
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			aluNot: result = ~a;
			aluLsl: begin
				result = {a[14:0], 1'b0};
				carry = a[15];         // Bit shifted out.
			end
			aluLsr: begin
				result = {1'b0, a[15:1]};
				carry = a[0];
			end
			default: result = a;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			flagsQ <= '0;
		end else if (ctrl.flagWrite) begin
			flagsQ.z <= (result == 16'd0);
			flagsQ.c <= carry;
			flagsQ.n <= result[15];
		end
	end

	assign ctrl.flags = flagsQ;

endmodule

`default_nettype wire

/* hw/cpuSystem.sv */
`default_nettype none

module cpuSystem import cpuPkg::*; #(
	parameter addrT resetPc = 16'h0000
) (
	input  wire logic Clock,
	input  wire logic rstN,
	output logic      wbCyc,
	output logic      wbStb,
	output logic      wbWe,
	output addrT      wbAdr,
	output wordT      wbDatW,
	input  wire wordT wbDatR,
	input  wire logic wbAck
);

	wordT rdA;
	wordT rdB;
	wordT aluResult;

	ctrlIf ctrlBus ();

	controlUnit u_controlUnit (
		.Clock  (Clock),
		.rstN   (rstN),
		.ctrl   (ctrlBus.control),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAck  (wbAck),
		.wbDatR (wbDatR)
	);

	registerFile u_registerFile (
		.Clock     (Clock),
		.rstN      (rstN),
		.ctrl      (ctrlBus.regs),
		.aluResult (aluResult),
		.busData   (wbDatR),
		.rdA       (rdA),
		.rdB       (rdB)
	);

	addressRegisters #(
		.resetPc (resetPc)
	) u_addressRegisters (
		.Clock   (Clock),
		.rstN    (rstN),
		.ctrl    (ctrlBus.addr),
		.rdA     (rdA),
		.busAddr (wbAdr)
	);

	alu u_alu (
		.Clock  (Clock),
		.rstN   (rstN),
		.ctrl   (ctrlBus.alu),
		.a      (rdA),
		.b      (rdB),
		.result (aluResult)
	);

	assign wbDatW = rdA;           // ST drives Rx through port A.

endmodule

`default_nettype wire

/* test/tbClockGen.sv */
`default_nettype none

module tbClockGen #(
	parameter int periodNs    = 10,
	parameter int resetCycles = 16
) (
	output logic Clock,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		Clock = 1'b0;
		forever #(periodNs / 2) Clock = ~Clock;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge Clock);
		#1 rstN = 1'b1;              // Released just after an edge.
	end

endmodule

`default_nettype wire

/* test/cpuSystem_chk.sv */
`default_nettype none

module cpuSystem_chk import cpuPkg::*; (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic wbAck,
	input wire addrT wbAdr,
	input wire wordT wbDatW
);

	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;               // Read by the testbench at the end.

	stbNeedsCyc: assert property (@(posedge Clock) disable iff (!rstN) wbStb |-> wbCyc)
		else begin
			$error("wbStb high without wbCyc");
			failCount++;
		end

	// Master holds the request until the slave answers.
	heldUntilAck: assert property (@(posedge Clock) disable iff (!rstN)
		(wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
		else begin
			$error("wbAdr, wbWe or wbDatW changed while waiting for wbAck");
			failCount++;
		end

	stbDropsAfterAck: assert property (@(posedge Clock) disable iff (!rstN)
		(wbStb && wbAck) |=> !wbStb)
		else begin
			$error("wbStb still high in the cycle after wbAck");
			failCount++;
		end

	idleInReset: assert property (@(posedge Clock) !rstN |-> !wbCyc)
		else begin
			$error("wbCyc high during reset");
			failCount++;
		end

endmodule

`default_nettype wire

/* test/tbCpuSystem.sv */
`default_nettype none

module tbCpuSystem import cpuPkg::*; ;

	timeunit 1ns;
	timeprecision 100ps;

	localparam addrT resetPc     = 16'h0000;
	localparam int   numInstr    = 3000;
	localparam int   worstCycles = 12;  // Fetch with waits, execute, data access.
	localparam int   watchdogNs  = (16 + numInstr * worstCycles + 100) * 10;

	logic Clock;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	addrT wbAdr;
	wordT wbDatW;
	wordT wbDatR;
	logic wbAck;

	wordT        mem [256];
	logic [31:0] rngState = 32'h48efe759;
	opcodeT      opTable [16] = '{opBra, opBne, opBeq, opLsl, opLsr, opAnd, opOrr, opNot,
		opXor, opMovh, opLd, opSt, opMovl, opAdd, opSub, opMovar};

	// Instruction-set model state.
	wordT   modelRegs [4];
	addrT   modelPc;
	addrT   modelAr;
	flagsT  modelFlags;
	logic   dataPhase;                 // Next transfer is LD or ST.
	logic   memIsStore;
	regIdxT memRx;

	int   fetchCount = 0;
	int   addrErrors = 0;
	int   dataErrors = 0;
	int   ctrlErrors = 0;
	logic busy = 1'b0;
	int   waitLeft = 0;

	tbClockGen #(.periodNs(10), .resetCycles(16)) u_tbClockGen (
		.Clock (Clock),
		.rstN  (rstN)
	);

	cpuSystem #(.resetPc(resetPc)) u_cpuSystem (
		.Clock  (Clock),
		.rstN   (rstN),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW),
		.wbDatR (wbDatR),
		.wbAck  (wbAck)
	);

	bind cpuSystem cpuSystem_chk u_chk (
		.Clock  (Clock),
		.rstN   (rstN),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAck  (wbAck),
		.wbAdr  (wbAdr),
		.wbDatW (wbDatW)
	);

	// ##########################################################
	// Random numbers and program image
	// ##########################################################

	function automatic logic [31:0] xorshift32();
		logic [31:0] s;
		s = rngState;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rngState = s;
		return s;
	endfunction

	task automatic fillMemory();
		logic [31:0] r;
		opcodeT op;
		for (int i = 0; i < 256; i++) begin
			r = xorshift32();
			op = opTable[r[31:28]];
			if (op == opBra || op == opBne || op == opBeq) begin
				mem[i] = {op, r[9:8], r[4], 3'b000, r[3:0]};  // Offset 0 to 15 or -128 to -113.
			end else begin
				mem[i] = {op, r[9:0]};
			end
		end
	endtask

	// ##########################################################
	// Compare tasks
	// ##########################################################

	task automatic checkAddr(string name, addrT expected, addrT actual);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			addrErrors++;
		end
	endtask

	task automatic checkData(string name, wordT expected, wordT actual);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			dataErrors++;
		end
	endtask

	task automatic checkBit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
			ctrlErrors++;
		end
	endtask

	// ##########################################################
	// Instruction-set model
	// ##########################################################

	task automatic executeModel(instrT ins);
		wordT        a;
		wordT        b;
		wordT        res;
		logic [16:0] wide;
		logic        carry;
		logic        aluInstr;
		addrT        offset;
		a = modelRegs[ins.rType.src1];
		b = modelRegs[ins.rType.src2];
		res = a;
		carry = modelFlags.c;           // Logic ops keep the carry.
		aluInstr = 1'b1;
		offset = {{8{ins.iType.imm[7]}}, ins.iType.imm};
		case (ins.rType.opcode)
			opAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[15:0];
				carry = wide[16];
			end
			opSub: begin
				wide = {1'b0, a} + {1'b0, ~b} + 17'd1;
				res = wide[15:0];
				carry = wide[16];
			end
			opAnd: res = a & b;
			opOrr: res = a | b;
			opXor: res = a ^ b;
			opNot: res = ~a;
			opLsl: begin
				res = a << 1;
				carry = a[15];
			end
			opLsr: begin
				res = a >> 1;
				carry = a[0];
			end
			default: aluInstr = 1'b0;
		endcase
		if (aluInstr) begin
			modelRegs[ins.rType.dst] = res;
			if (ins.rType.setFlags) begin
				modelFlags.z = (res == 16'd0);
				modelFlags.c = carry;
				modelFlags.n = res[15];
			end
		end
		case (ins.iType.opcode)
			opMovl: modelRegs[ins.iType.rx][7:0] = ins.iType.imm;
			opMovh: modelRegs[ins.iType.rx][15:8] = ins.iType.imm;
			opMovar: modelAr = modelRegs[ins.iType.rx];
			opBra: modelPc = modelPc + offset;   // PC already points past the branch.
			opBeq: if (modelFlags.z) modelPc = modelPc + offset;
			opBne: if (!modelFlags.z) modelPc = modelPc + offset;
			opLd, opSt: begin
				dataPhase = 1'b1;
				memIsStore = (ins.iType.opcode == opSt);
				memRx = ins.iType.rx;
			end
			default: ;
		endcase
	endtask

	// One completed Wishbone transfer, checked against the model.
	task automatic completeTransfer();
		checkBit("wbCyc", 1'b1, wbCyc);
		if (!dataPhase) begin
			checkAddr("wbAdr", modelPc, wbAdr);
			checkBit("wbWe", 1'b0, wbWe);
			wbDatR = mem[wbAdr[7:0]];
			modelPc = modelPc + 16'd1;
			executeModel(mem[modelPc[7:0] - 8'd1]);
			fetchCount++;
		end else begin
			checkAddr("wbAdr", modelAr, wbAdr);
			checkBit("wbWe", memIsStore, wbWe);
			if (memIsStore) begin
				checkData("wbDatW", modelRegs[memRx], wbDatW);
				mem[modelAr[7:0]] = modelRegs[memRx];
			end else begin
				wbDatR = mem[wbAdr[7:0]];
				modelRegs[memRx] = mem[modelAr[7:0]];
			end
			dataPhase = 1'b0;
		end
	endtask

	function automatic int totalErrors();
		return addrErrors + dataErrors + ctrlErrors + u_cpuSystem.u_chk.failCount;
	endfunction

	task automatic reportCounts();
		$display("Errors: address %0d, data %0d, control %0d, assertion %0d",
			addrErrors, dataErrors, ctrlErrors, u_cpuSystem.u_chk.failCount);
	endtask

	// ##########################################################
	// Memory slave, main flow and watchdog
	// ##########################################################

	initial begin
		forever begin
			@(posedge Clock);
			#1;
			if (wbAck) begin
				wbAck = 1'b0;              // Single-cycle acknowledge.
			end else if (wbStb) begin
				if (!busy) begin
					busy = 1'b1;
					waitLeft = int'(xorshift32() % 32'd4);
				end
				if (waitLeft == 0) begin
					completeTransfer();
					wbAck = 1'b1;
					busy = 1'b0;
				end else begin
					waitLeft--;
				end
			end
		end
	end

	initial begin
		wbAck = 1'b0;
		wbDatR = '0;
		modelPc = resetPc;
		modelAr = '0;
		modelFlags = '0;
		dataPhase = 1'b0;
		memIsStore = 1'b0;
		memRx = '0;
		for (int i = 0; i < 4; i++) begin
			modelRegs[i] = '0;
		end
		fillMemory();
		wait (fetchCount >= numInstr);
		repeat (4) @(posedge Clock);
		reportCounts();
		if (totalErrors() == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#watchdogNs;
		$display("Watchdog expired with %0d of %0d instructions fetched", fetchCount, numInstr);
		reportCounts();
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
common/cpuPkg.sv
common/ctrlIf.sv
controlUnit/controlUnit.sv
datapath/registerFile.sv
datapath/addressRegisters.sv
datapath/alu.sv
hw/cpuSystem.sv
test/tbClockGen.sv
test/cpuSystem_chk.sv
test/tbCpuSystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCpuSystem
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASSTEXT  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
